//--- source/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// core reset length, counted from the last reset request.
`define RESET_HOLD_CYCLES 32

// the power button must hold one level this long before it is accepted.
`define DEBOUNCE_CYCLES 16

// limits on the supply power-good answers.
`define ATX_TIMEOUT_CYCLES 64
`define RAIL_TIMEOUT_CYCLES 64

// settle time once all rails are up, and grace time for an orderly shutdown.
`define POST_POWERUP_CYCLES 16
`define POWER_DOWN_CYCLES 16

// supply vector widths.
`define NUM_INHIBITS 5
`define NUM_MGT_RAILS 3

// counter widths. all cycle counts above must fit in CNT_WIDTH.
`define CNT_WIDTH 8
`define BLINK_WIDTH 8

// blink counter taps for the LED patterns.
`define BLINK_FAST_BIT 3
`define BLINK_SLOW_BIT 5

`endif

//--- source/board_types_pkg.sv
`include "board_macros.svh"

package board_types_pkg;

  // one bit per point-of-load inhibit.
  // a high bit holds that regulator off.
  typedef logic [`NUM_INHIBITS-1:0] inhibit_vec_t;

  // one bit per transceiver rail, in the order avcc, avttx, avccpll.
  // the same layout serves the enables and the power-goods.
  typedef logic [`NUM_MGT_RAILS-1:0] mgt_vec_t;

  // timing counter for reset stretch, debounce, timeouts and settle.
  typedef logic [`CNT_WIDTH-1:0] cycle_cnt_t;

  // free-running counter behind the chassis LED blink patterns.
  typedef logic [`BLINK_WIDTH-1:0] blink_cnt_t;

endpackage

//--- source/power_state_pkg.sv
package power_state_pkg;

  // supply sequencer states.
  typedef enum logic [2:0] {
    ST_OFF        = 3'd0,
    ST_ATX_WAIT   = 3'd1,
    ST_RAIL_WAIT  = 3'd2,
    ST_SETTLE     = 3'd3,
    ST_ON         = 3'd4,
    ST_POWER_DOWN = 3'd5
  } pwr_state_e;

  // why the board was last powered off.
  typedef enum logic [1:0] {
    CAUSE_NONE = 2'd0,
    CAUSE_ATX  = 2'd1,
    CAUSE_RAIL = 2'd2,
    CAUSE_USER = 2'd3
  } off_cause_e;

endpackage

//--- source/power_status_if.sv
interface power_status_if
  import power_state_pkg::*;
();

  logic       power_ok;
  logic       power_on;
  logic       powerdown_pending;
  off_cause_e off_cause;

  // all four are levels owned by the sequencer.
  modport sequencer (
    output power_ok,
    output power_on,
    output powerdown_pending,
    output off_cause
  );

  modport indicator (
    input power_ok,
    input power_on,
    input powerdown_pending,
    input off_cause
  );

endinterface

//--- source/chassis_input.sv
`include "board_macros.svh"

module chassis_input
  import board_types_pkg::*;
(
  input  logic gclk40,
  input  logic hard_reset,
  input  logic chs_reset_n_i,
  input  logic xport_reset_n_i,
  input  logic chs_powerdown_n_i,
  output logic core_rst_n_o,
  output logic button_press_o
);

  logic       xport_reset_n_q;
  logic       reset_req;
  cycle_cnt_t hold_cnt;
  logic       btn_sample;
  logic       btn_level;
  logic       btn_level_q;
  cycle_cnt_t stable_cnt;

  // the network module asks for a reset by toggling its line, in either direction.
  assign reset_req = !chs_reset_n_i || (xport_reset_n_q != xport_reset_n_i);

  // every request reloads the stretcher, so the core leaves reset
  // RESET_HOLD_CYCLES after the last one.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      xport_reset_n_q <= 1'b1;
      hold_cnt        <= cycle_cnt_t'(`RESET_HOLD_CYCLES - 1);
      core_rst_n_o    <= 1'b0;
    end else begin
      xport_reset_n_q <= xport_reset_n_i;
      if (reset_req) begin
        hold_cnt <= cycle_cnt_t'(`RESET_HOLD_CYCLES - 1);
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      core_rst_n_o <= !reset_req && (hold_cnt == '0);
    end
  end

  // the button is active low on the chassis.
  // the debounced level only moves after the sample has differed from it
  // for DEBOUNCE_CYCLES cycles in a row.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      btn_sample     <= 1'b0;
      btn_level      <= 1'b0;
      btn_level_q    <= 1'b0;
      stable_cnt     <= '0;
      button_press_o <= 1'b0;
    end else begin
      btn_sample     <= !chs_powerdown_n_i;
      btn_level_q    <= btn_level;
      button_press_o <= btn_level && !btn_level_q;
      if (btn_sample == btn_level) begin
        stable_cnt <= '0;
      end else if (stable_cnt == cycle_cnt_t'(`DEBOUNCE_CYCLES - 1)) begin
        btn_level  <= btn_sample;
        stable_cnt <= '0;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

//--- source/power_sequencer.sv
`include "board_macros.svh"

module power_sequencer
  import board_types_pkg::*;
  import power_state_pkg::*;
(
  input  logic                     gclk40,
  input  logic                     hard_reset,
  input  logic                     core_rst_n_i,
  input  logic                     button_press_i,
  input  logic                     atx_pwr_ok_i,
  input  logic                     aux_3v3_pg_i,
  input  mgt_vec_t                 mgt_pg_i,
  output logic                     atx_ps_on_n_o,
  output inhibit_vec_t             inhibit_o,
  output mgt_vec_t                 mgt_en_o,
  power_status_if.sequencer        status
);

  pwr_state_e state;
  cycle_cnt_t cnt;
  off_cause_e cause;
  logic       rails_ok;
  logic       supply_fault;
  off_cause_e fault_cause;
  logic       rails_on;

  // once the rails are up the aux 3v3 supply counts as one of them.
  assign rails_ok     = (&mgt_pg_i) && aux_3v3_pg_i;
  assign supply_fault = !atx_pwr_ok_i || !rails_ok;
  assign fault_cause  = !atx_pwr_ok_i ? CAUSE_ATX : CAUSE_RAIL;

  // cnt is shared. it is loaded with the length of the state on entry and
  // the state ends when it reaches zero.
  always_ff @(posedge gclk40) begin
    if (!hard_reset || !core_rst_n_i) begin
      state <= ST_OFF;
      cnt   <= '0;
      cause <= CAUSE_NONE;
    end else begin
      case (state)
        ST_OFF: begin
          if (button_press_i) begin
            state <= ST_ATX_WAIT;
            cnt   <= cycle_cnt_t'(`ATX_TIMEOUT_CYCLES - 1);
          end
        end
        ST_ATX_WAIT: begin
          if (atx_pwr_ok_i) begin
            state <= ST_RAIL_WAIT;
            cnt   <= cycle_cnt_t'(`RAIL_TIMEOUT_CYCLES - 1);
          end else if (cnt == '0) begin
            state <= ST_OFF;
            cause <= CAUSE_ATX;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_RAIL_WAIT: begin
          if (!atx_pwr_ok_i) begin
            state <= ST_OFF;
            cause <= CAUSE_ATX;
          end else if (&mgt_pg_i) begin
            state <= ST_SETTLE;
            cnt   <= cycle_cnt_t'(`POST_POWERUP_CYCLES - 1);
          end else if (cnt == '0) begin
            state <= ST_OFF;
            cause <= CAUSE_RAIL;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_SETTLE: begin
          if (supply_fault) begin
            state <= ST_OFF;
            cause <= fault_cause;
          end else if (cnt == '0) begin
            state <= ST_ON;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_ON: begin
          if (supply_fault) begin
            state <= ST_OFF;
            cause <= fault_cause;
          end else if (button_press_i) begin
            state <= ST_POWER_DOWN;
            cnt   <= cycle_cnt_t'(`POWER_DOWN_CYCLES - 1);
          end
        end
        ST_POWER_DOWN: begin
          // a failing supply still wins over the orderly shutdown.
          if (supply_fault) begin
            state <= ST_OFF;
            cause <= fault_cause;
          end else if (cnt == '0) begin
            state <= ST_OFF;
            cause <= CAUSE_USER;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= ST_OFF;
        end
      endcase
    end
  end

  assign rails_on = state inside {ST_RAIL_WAIT, ST_SETTLE, ST_ON, ST_POWER_DOWN};

  assign atx_ps_on_n_o = (state == ST_OFF);
  assign inhibit_o     = rails_on ? '0 : '1;
  assign mgt_en_o      = rails_on ? '1 : '0;

  // the controller keeps running through the shutdown grace time.
  assign status.power_ok          = (state == ST_ON) || (state == ST_POWER_DOWN);
  assign status.power_on          = (state != ST_OFF);
  assign status.powerdown_pending = (state == ST_POWER_DOWN);
  assign status.off_cause         = cause;

endmodule

//--- source/chassis_indicator.sv
`include "board_macros.svh"

module chassis_indicator
  import board_types_pkg::*;
  import power_state_pkg::*;
(
  input  logic              gclk40,
  input  logic              hard_reset,
  input  logic              core_rst_n_i,
  power_status_if.indicator status,
  output logic [1:0]        chs_led_n_o,
  output logic              controller_reset_o,
  output logic              controller_irq_o
);

  blink_cnt_t blink_cnt;
  logic       bad_power_down;
  logic       power_led;
  logic       action_led;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      blink_cnt <= '0;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  assign bad_power_down = status.off_cause inside {CAUSE_ATX, CAUSE_RAIL};

  // a failure keeps blinking until the next power-up attempt starts.
  assign power_led = status.power_ok ? 1'b1 :
                     (bad_power_down && !status.power_on) ? blink_cnt[`BLINK_FAST_BIT] :
                     1'b0;

  assign action_led = status.power_ok ? status.powerdown_pending : blink_cnt[`BLINK_SLOW_BIT];

  // lamp test while the core is held in reset. both LEDs are active low.
  assign chs_led_n_o = core_rst_n_i ? ~{action_led, power_led} : 2'b00;

  assign controller_reset_o = !status.power_ok;
  assign controller_irq_o   = status.powerdown_pending;

endmodule

//--- source/board_ctrl_top.sv
module board_ctrl_top
  import board_types_pkg::*;
(
  input  logic         gclk40,
  input  logic         hard_reset,
  input  logic         chs_reset_n_i,
  input  logic         xport_reset_n_i,
  input  logic         chs_powerdown_n_i,
  input  logic         atx_pwr_ok_i,
  input  logic         aux_3v3_pg_i,
  input  mgt_vec_t     mgt_pg_i,
  output logic         atx_ps_on_n_o,
  output inhibit_vec_t inhibit_o,
  output mgt_vec_t     mgt_en_o,
  output logic [1:0]   chs_led_n_o,
  output logic         controller_reset_o,
  output logic         controller_irq_o
);

  logic core_rst_n;
  logic button_press;

  power_status_if u_status ();

  chassis_input u_chassis_input (
    .gclk40            (gclk40),
    .hard_reset        (hard_reset),
    .chs_reset_n_i     (chs_reset_n_i),
    .xport_reset_n_i   (xport_reset_n_i),
    .chs_powerdown_n_i (chs_powerdown_n_i),
    .core_rst_n_o      (core_rst_n),
    .button_press_o    (button_press)
  );

  power_sequencer u_power_sequencer (
    .gclk40         (gclk40),
    .hard_reset     (hard_reset),
    .core_rst_n_i   (core_rst_n),
    .button_press_i (button_press),
    .atx_pwr_ok_i   (atx_pwr_ok_i),
    .aux_3v3_pg_i   (aux_3v3_pg_i),
    .mgt_pg_i       (mgt_pg_i),
    .atx_ps_on_n_o  (atx_ps_on_n_o),
    .inhibit_o      (inhibit_o),
    .mgt_en_o       (mgt_en_o),
    .status         (u_status.sequencer)
  );

  chassis_indicator u_chassis_indicator (
    .gclk40             (gclk40),
    .hard_reset         (hard_reset),
    .core_rst_n_i       (core_rst_n),
    .status             (u_status.indicator),
    .chs_led_n_o        (chs_led_n_o),
    .controller_reset_o (controller_reset_o),
    .controller_irq_o   (controller_irq_o)
  );

endmodule

//--- verif/tb_board_ctrl.sv
`include "board_macros.svh"

module tb_board_ctrl
  import board_types_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_ROWS = 6;
  localparam int LED_LIT = 0;
  localparam int LED_DARK = 1;
  localparam int LED_BLINK = 2;
  localparam int BLINK_WINDOW = 2 ** (`BLINK_FAST_BIT + 2);
  localparam int SEQ_LIMIT = `ATX_TIMEOUT_CYCLES + `RAIL_TIMEOUT_CYCLES + `POST_POWERUP_CYCLES;
  localparam int CYCLE_SUM = `RESET_HOLD_CYCLES + `DEBOUNCE_CYCLES + `ATX_TIMEOUT_CYCLES +
                             `RAIL_TIMEOUT_CYCLES + `POST_POWERUP_CYCLES + `POWER_DOWN_CYCLES;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * CYCLE_SUM * 4;
  localparam logic [7:0] INH_ALL = 8'((1 << `NUM_INHIBITS) - 1);
  localparam logic [7:0] MGT_ALL = 8'((1 << `NUM_MGT_RAILS) - 1);

  // selectors for the outputs that the bounded waits watch.
  localparam int SEL_ATX_OFF = 0;
  localparam int SEL_RAILS_EN = 1;
  localparam int SEL_CTRL_RESET = 2;
  localparam int SEL_IRQ = 3;

  // one stimulus row with the final state that it must reach.
  typedef struct packed {
    int   hold;
    logic atx_ans;
    logic rail_ans;
    logic rail_drop;
    logic exp_on;
    int   led;
  } row_t;

  logic         gclk40;
  logic         hard_reset;
  logic         chs_reset_n_i;
  logic         xport_reset_n_i;
  logic         chs_powerdown_n_i;
  logic         atx_pwr_ok_i;
  logic         aux_3v3_pg_i;
  mgt_vec_t     mgt_pg_i;
  logic         atx_ps_on_n_o;
  inhibit_vec_t inhibit_o;
  mgt_vec_t     mgt_en_o;
  logic [1:0]   chs_led_n_o;
  logic         controller_reset_o;
  logic         controller_irq_o;

  row_t  rows [NUM_ROWS];
  string row_name [NUM_ROWS];
  int    errors;
  int    seed;

  board_ctrl_top u_dut (
    .gclk40             (gclk40),
    .hard_reset         (hard_reset),
    .chs_reset_n_i      (chs_reset_n_i),
    .xport_reset_n_i    (xport_reset_n_i),
    .chs_powerdown_n_i  (chs_powerdown_n_i),
    .atx_pwr_ok_i       (atx_pwr_ok_i),
    .aux_3v3_pg_i       (aux_3v3_pg_i),
    .mgt_pg_i           (mgt_pg_i),
    .atx_ps_on_n_o      (atx_ps_on_n_o),
    .inhibit_o          (inhibit_o),
    .mgt_en_o           (mgt_en_o),
    .chs_led_n_o        (chs_led_n_o),
    .controller_reset_o (controller_reset_o),
    .controller_irq_o   (controller_irq_o)
  );

  always #(CLK_PERIOD / 2) gclk40 = ~gclk40;

  function automatic logic probe(input int sel);
    case (sel)
      SEL_ATX_OFF:    probe = atx_ps_on_n_o;
      SEL_RAILS_EN:   probe = &mgt_en_o;
      SEL_CTRL_RESET: probe = controller_reset_o;
      default:        probe = controller_irq_o;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // outputs are sampled on the falling edge, half a period away from any change.
  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what);
    int n;
    n = 0;
    @(negedge gclk40);
    while (probe(sel) !== level && n < limit) begin
      @(negedge gclk40);
      n++;
    end
    assert (probe(sel) === level) else begin
      $display("at %0t: %s did not happen within %0d cycles", $time, what, limit);
      errors++;
    end
  endtask

  task automatic press_button(input int hold);
    @(posedge gclk40);
    chs_powerdown_n_i <= 1'b0;
    repeat (hold) @(posedge gclk40);
    chs_powerdown_n_i <= 1'b1;
  endtask

  // a supply answers 1 to 20 cycles after it is switched on.
  task automatic random_delay();
    int n;
    n = 1 + int'($unsigned($random(seed)) % 20);
    repeat (n) @(posedge gclk40);
  endtask

  task automatic check_led(input int pattern);
    int   n;
    logic seen_low;
    logic seen_high;
    seen_low = 1'b0;
    seen_high = 1'b0;
    for (n = 0; n < BLINK_WINDOW; n++) begin
      @(negedge gclk40);
      if (chs_led_n_o[0] === 1'b0) begin
        seen_low = 1'b1;
      end else begin
        seen_high = 1'b1;
      end
    end
    if (pattern == LED_LIT) begin
      assert (!seen_high) else begin
        $display("FAILED at %0t: chs_led_n_o[0] expected steady 0, got 1", $time);
        errors++;
      end
    end else if (pattern == LED_DARK) begin
      assert (!seen_low) else begin
        $display("FAILED at %0t: chs_led_n_o[0] expected steady 1, got 0", $time);
        errors++;
      end
    end else begin
      assert (seen_low && seen_high) else begin
        $display("at %0t: the power LED did not blink within %0d cycles", $time,
                 BLINK_WINDOW);
        errors++;
      end
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int   r;
    int   err_before;
    logic was_on;
    gclk40 = 1'b0;
    hard_reset = 1'b0;
    chs_reset_n_i = 1'b1;
    xport_reset_n_i = 1'b1;
    chs_powerdown_n_i = 1'b1;
    atx_pwr_ok_i = 1'b0;
    aux_3v3_pg_i = 1'b1;
    mgt_pg_i = '0;
    errors = 0;
    seed = 32'h39e473c8;

    rows[0] = '{8, 1'b1, 1'b1, 1'b0, 1'b0, LED_DARK};
    rows[1] = '{24, 1'b1, 1'b1, 1'b0, 1'b1, LED_LIT};
    rows[2] = '{24, 1'b1, 1'b1, 1'b0, 1'b0, LED_DARK};
    rows[3] = '{24, 1'b0, 1'b0, 1'b0, 1'b0, LED_BLINK};
    rows[4] = '{24, 1'b1, 1'b1, 1'b1, 1'b0, LED_BLINK};
    rows[5] = '{24, 1'b1, 1'b0, 1'b0, 1'b0, LED_BLINK};
    row_name[0] = "glitch";
    row_name[1] = "power-up";
    row_name[2] = "power-down";
    row_name[3] = "ATX timeout";
    row_name[4] = "rail loss";
    row_name[5] = "rail timeout";

    repeat (8) @(posedge gclk40);
    hard_reset <= 1'b1;

    // the core reset is still stretched here, so both LEDs are lit.
    @(negedge gclk40);
    check_value("chs_led_n_o", 8'(chs_led_n_o), 8'h00);
    check_value("atx_ps_on_n_o", 8'(atx_ps_on_n_o), 8'h01);
    check_value("inhibit_o", 8'(inhibit_o), INH_ALL);
    check_value("mgt_en_o", 8'(mgt_en_o), 8'h00);
    wait_level(SEL_CTRL_RESET, 1'b1, 4, "controller reset after reset");
    repeat (`RESET_HOLD_CYCLES + 4) @(negedge gclk40);
    check_value("chs_led_n_o[0]", 8'(chs_led_n_o[0]), 8'h01);
    $display("reset: %s", (errors == 0) ? "passed" : "failed");

    for (r = 0; r < NUM_ROWS; r++) begin
      err_before = errors;
      // the previous row of the table says whether power is on now.
      was_on = (r == 0) ? 1'b0 : rows[r - 1].exp_on;
      press_button(rows[r].hold);
      if (rows[r].hold < `DEBOUNCE_CYCLES) begin
        repeat (2 * `DEBOUNCE_CYCLES) begin
          @(negedge gclk40);
          check_value("atx_ps_on_n_o", 8'(atx_ps_on_n_o), 8'h01);
          if (atx_ps_on_n_o !== 1'b1) begin
            break;
          end
        end
      end else if (was_on) begin
        wait_level(SEL_IRQ, 1'b1, `DEBOUNCE_CYCLES, "interrupt after the press");
        // the action LED shows the pending interrupt while power is still good.
        check_value("chs_led_n_o[1]", 8'(chs_led_n_o[1]), 8'h00);
        wait_level(SEL_CTRL_RESET, 1'b1, `POWER_DOWN_CYCLES + 8, "orderly power-down");
      end else begin
        wait_level(SEL_ATX_OFF, 1'b0, `DEBOUNCE_CYCLES, "ATX on after the press");
        if (rows[r].atx_ans) begin
          random_delay();
          atx_pwr_ok_i <= 1'b1;
          wait_level(SEL_RAILS_EN, 1'b1, 8, "rail enables after ATX power-good");
          if (rows[r].rail_ans) begin
            random_delay();
            mgt_pg_i <= '1;
          end
        end
        if (rows[r].atx_ans && rows[r].rail_ans) begin
          wait_level(SEL_CTRL_RESET, 1'b0, SEQ_LIMIT, "power good after the settle time");
        end
        if (rows[r].rail_drop) begin
          @(posedge gclk40);
          mgt_pg_i[1] <= 1'b0;
        end
        if (!rows[r].exp_on) begin
          wait_level(SEL_ATX_OFF, 1'b1, SEQ_LIMIT, "supplies off");
        end
      end

      // the supplies lose their power-goods once they are switched off.
      if (!rows[r].exp_on) begin
        @(posedge gclk40);
        atx_pwr_ok_i <= 1'b0;
        mgt_pg_i <= '0;
      end
      @(negedge gclk40);
      check_value("atx_ps_on_n_o", 8'(atx_ps_on_n_o), 8'(!rows[r].exp_on));
      check_value("inhibit_o", 8'(inhibit_o), rows[r].exp_on ? 8'h00 : INH_ALL);
      check_value("mgt_en_o", 8'(mgt_en_o), rows[r].exp_on ? MGT_ALL : 8'h00);
      check_value("controller_reset_o", 8'(controller_reset_o), 8'(!rows[r].exp_on));
      check_value("controller_irq_o", 8'(controller_irq_o), 8'h00);
      if (rows[r].exp_on) begin
        check_value("chs_led_n_o[1]", 8'(chs_led_n_o[1]), 8'h01);
      end
      check_led(rows[r].led);
      $display("row %0d %s: %s", r, row_name[r], (errors == err_before) ? "passed" : "failed");
    end

    $display("rows run: %0d, errors: %0d", NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/board_types_pkg.sv
source/power_state_pkg.sv
source/power_status_if.sv
source/chassis_input.sv
source/power_sequencer.sv
source/chassis_indicator.sv
source/board_ctrl_top.sv
verif/tb_board_ctrl.sv

//--- Makefile
# Verilator build for the board control testbench.

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_board_ctrl
RTL_TOP   ?= board_ctrl_top
INC_DIR   ?= source
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
SIM_FLAGS ?= --binary --timing --assert

RTL_SRCS := $(filter source/%.sv,$(shell cat $(FLIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+$(INC_DIR) $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
